// File: Bender.yml
package:
  name: cr16_core

sources:
  # rtl in compile order
  - hw/cr16_pkg.sv
  - hw/cr16_ctrl_if.sv
  - hw/control_and_decoder.sv
  - hw/cr16_fetch.sv
  - hw/cr16_regfile.sv
  - hw/cr16_alu.sv
  - hw/cr16_core.sv
  # testbench
  - target: test
    include_dirs:
      - test
    files:
      - test/cr16_tb.sv

// File: filelist.f
+incdir+test
hw/cr16_pkg.sv
hw/cr16_ctrl_if.sv
hw/control_and_decoder.sv
hw/cr16_fetch.sv
hw/cr16_regfile.sv
hw/cr16_alu.sv
hw/cr16_core.sv
test/cr16_tb.sv

// File: hw/control_and_decoder.sv
// cr16 sequencing FSM walking fetch, decode and execute, with the instruction field decoder
`timescale 1ns/1ns
module control_and_decoder (
    input  logic            clk,
    input  logic            reset,
    input  logic            instr_valid,
    output logic            instr_ready,
    input  cr16_pkg::word_t instr,       // instruction register value
    output logic            pc_en,
    output logic            ir_en,
    cr16_ctrl_if.ctrl       ctrl
);
    import cr16_pkg::*;

    typedef enum logic [1:0] {
        FETCH,
        DECODE,
        EXECUTE
    } state_t;

    state_t state;
    state_t state_nxt;

    logic    reg_form; // upper nibble zero
    opcode_t raw_op;
    opcode_t dec_op;   // after undefined codes fold to nop

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= FETCH;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            FETCH:   if (instr_valid) state_nxt = DECODE; // wait here on an empty source
            DECODE:  state_nxt = EXECUTE;
            EXECUTE: state_nxt = FETCH;
            default: state_nxt = FETCH;
        endcase
    end

    // field decode
    assign reg_form = (instr[15:12] == 4'd0);
    assign raw_op   = reg_form ? instr[7:4] : instr[15:12];

    always_comb begin
        // 14 and 15 have no meaning and run as nop
        if (raw_op > OP_MOV) begin
            dec_op = OP_NOP;
        end else begin
            dec_op = raw_op;
        end
    end

    assign instr_ready = (state == FETCH);
    assign ir_en       = instr_ready && instr_valid; // load on the accepting edge
    assign pc_en       = (state == EXECUTE);         // pc steps as execute ends

    always_comb begin
        // idle bus while fetching
        ctrl.exec   = 1'b0;
        ctrl.reg_we = 1'b0;
        ctrl.imm_en = 1'b0;
        ctrl.op     = OP_NOP;
        ctrl.rsrc   = '0;
        ctrl.rdest  = '0;
        ctrl.imm8   = '0;
        if (state != FETCH) begin
            ctrl.imm_en = !reg_form;
            ctrl.op     = dec_op;
            ctrl.rsrc   = instr[3:0];
            ctrl.rdest  = instr[11:8];
            ctrl.imm8   = instr[7:0];
        end
        if (state == EXECUTE) begin
            ctrl.exec   = 1'b1;
            // compare and nop only touch flags
            ctrl.reg_we = (dec_op != OP_CMP) && (dec_op != OP_NOP);
        end
    end

    // an accepted instruction keeps ready low for two cycles and executes on the second
    a_ready_fetch_only: assert property (
        @(posedge clk) disable iff (!reset)
        ir_en |=> !instr_ready && !ctrl.exec ##1 !instr_ready && ctrl.exec
    );

    // writeback only inside execute and then straight back to fetch
    a_we_in_exec: assert property (
        @(posedge clk) disable iff (!reset)
        ctrl.reg_we |-> ctrl.exec ##1 instr_ready
    );

endmodule

// File: hw/cr16_alu.sv
// cr16 alu with operand selection, immediate extension, all operations and the flag register
`timescale 1ns/1ns
module cr16_alu (
    input  logic             clk,
    input  logic             reset,
    cr16_ctrl_if.alu         ctrl,
    input  cr16_pkg::word_t  a,      // destination register value
    input  cr16_pkg::word_t  b_reg,  // source register value
    output cr16_pkg::word_t  result,
    output cr16_pkg::flags_t flags
);
    import cr16_pkg::*;

    word_t        b;
    logic         sext;        // arithmetic ops want a signed immediate
    logic         cin;         // carry or borrow into bit 0
    logic [16:0]  sum;
    logic [16:0]  diff;
    logic [4:0]   cnt;
    logic [4:0]   amt;         // magnitude of a negative count
    flags_t       flags_q;
    flags_t       flags_nxt;

    always_comb begin
        case (ctrl.op)
            OP_ADD, OP_ADDU, OP_ADDC, OP_SUB, OP_SUBC, OP_CMP, OP_MOV: sext = 1'b1;
            default: sext = 1'b0;
        endcase
    end

    always_comb begin
        if (!ctrl.imm_en) begin
            b = b_reg;
        end else if (sext) begin
            b = {{8{ctrl.imm8[7]}}, ctrl.imm8};
        end else begin
            b = {8'h00, ctrl.imm8};
        end
    end

    // carry in only for the chained forms
    assign cin  = ((ctrl.op == OP_ADDC) || (ctrl.op == OP_SUBC)) ? flags_q[FLAG_C] : 1'b0;
    assign sum  = {1'b0, a} + {1'b0, b} + {16'd0, cin};
    assign diff = {1'b0, a} - {1'b0, b} - {16'd0, cin};
    assign cnt  = b[4:0];
    assign amt  = ~cnt + 5'd1;

    always_comb begin
        case (ctrl.op)
            OP_ADD, OP_ADDU, OP_ADDC: result = sum[15:0];
            OP_SUB, OP_SUBC, OP_CMP:  result = diff[15:0];
            OP_AND:  result = a & b;
            OP_OR:   result = a | b;
            OP_XOR:  result = a ^ b;
            OP_MOV:  result = b;
            OP_NOT:  result = ~b;
            OP_LSH:  result = cnt[4] ? (a >> amt) : (a << cnt);
            OP_ASHU: result = cnt[4] ? word_t'($signed(a) >>> amt) : (a << cnt);
            default: result = a; // nop passes a through
        endcase
    end

    always_comb begin
        flags_nxt = flags_q;
        case (ctrl.op)
            OP_ADD, OP_ADDC: begin
                flags_nxt[FLAG_C] = sum[16];
                flags_nxt[FLAG_F] = (a[15] == b[15]) && (sum[15] != a[15]);
            end
            OP_SUB, OP_SUBC: begin
                flags_nxt[FLAG_C] = diff[16]; // borrow out
                flags_nxt[FLAG_F] = (a[15] != b[15]) && (diff[15] != a[15]);
            end
            OP_CMP: begin
                flags_nxt[FLAG_Z] = (a == b);
                flags_nxt[FLAG_L] = (a < b);
                flags_nxt[FLAG_N] = ($signed(a) < $signed(b));
            end
            default: ;
        endcase
    end

    // flags land as execute ends and show one cycle after retire
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            flags_q <= '0;
        end else if (ctrl.exec) begin
            flags_q <= flags_nxt;
        end
    end

    assign flags = flags_q;

endmodule

// File: hw/cr16_core.sv
// cr16 multicycle execution core tying fetch, control, register file and alu together
`timescale 1ns/1ns
module cr16_core (
    input  logic               clk,
    input  logic               reset,
    // instruction stream
    input  logic               instr_valid,
    input  cr16_pkg::word_t    instr_data,
    output logic               instr_ready,
    // retire record that is always accepted
    output logic               retire_valid,
    output cr16_pkg::word_t    retire_pc,
    output logic               retire_we,
    output cr16_pkg::reg_idx_t retire_rdest,
    output cr16_pkg::word_t    retire_data,
    output cr16_pkg::flags_t   flags
);
    import cr16_pkg::*;

    cr16_ctrl_if ctrl_bus ();

    logic  pc_en;
    logic  ir_en;
    word_t instr;
    word_t pc;
    word_t dest_data;
    word_t src_data;
    word_t alu_result;

    control_and_decoder u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr),
        .pc_en       (pc_en),
        .ir_en       (ir_en),
        .ctrl        (ctrl_bus.ctrl)
    );

    cr16_fetch u_fetch (
        .clk         (clk),
        .reset       (reset),
        .instr_data  (instr_data),
        .instr_valid (instr_valid),
        .ir_en       (ir_en),
        .pc_en       (pc_en),
        .instr       (instr),
        .pc          (pc)
    );

    cr16_regfile u_regs (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl_bus.regs),
        .wdata     (alu_result),
        .dest_data (dest_data),
        .src_data  (src_data)
    );

    cr16_alu u_alu (
        .clk    (clk),
        .reset  (reset),
        .ctrl   (ctrl_bus.alu),
        .a      (dest_data),
        .b_reg  (src_data),
        .result (alu_result),
        .flags  (flags)
    );

    // retire is the execute cycle itself
    assign retire_valid = ctrl_bus.exec;
    assign retire_pc    = pc;
    assign retire_we    = ctrl_bus.reg_we;
    assign retire_rdest = ctrl_bus.rdest;
    assign retire_data  = alu_result;

endmodule

// File: hw/cr16_ctrl_if.sv
// cr16 control bus carrying decoded instruction fields from the FSM to regfile and alu
`timescale 1ns/1ns
interface cr16_ctrl_if;
    import cr16_pkg::*;

    logic               exec;   // high for the one execute cycle
    logic               reg_we; // writeback strobe
    logic               imm_en; // operand b from immediate
    opcode_t            op;     // decoded operation
    reg_idx_t           rsrc;   // source register
    reg_idx_t           rdest;  // destination register
    logic [IMM_W-1:0]   imm8;   // raw immediate field

    // FSM side drives everything
    modport ctrl (
        output exec, reg_we, imm_en, op, rsrc, rdest, imm8
    );

    // register file only needs indices and the write strobe
    modport regs (
        input rsrc, rdest, reg_we, exec
    );

    modport alu (
        input exec, imm_en, op, imm8
    );

endinterface

// File: hw/cr16_fetch.sv
// cr16 fetch stage holding the instruction register and the program counter
`timescale 1ns/1ns
module cr16_fetch (
    input  logic            clk,
    input  logic            reset,
    input  cr16_pkg::word_t instr_data,  // from the instruction source
    input  logic            instr_valid,
    input  logic            ir_en,       // handshake from control
    input  logic            pc_en,       // end of execute
    output cr16_pkg::word_t instr,
    output cr16_pkg::word_t pc
);
    import cr16_pkg::*;

    word_t ir_q;
    word_t pc_q;

    // instruction register, loads on the accepting edge
    always_ff @(posedge clk) begin
        if (ir_en) begin
            ir_q <= instr_data;
        end
    end

    // program counter counts instructions rather than bytes
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc_q <= '0;
        end else if (pc_en) begin
            pc_q <= pc_q + word_t'(1);
        end
    end

    assign instr = ir_q;
    assign pc    = pc_q; // still the old value while retiring

    // load strobe only with an offered instruction
    a_ir_needs_valid: assert property (
        @(posedge clk) disable iff (!reset)
        $rose(ir_en) |-> instr_valid
    );

    // pc never moves in the cycle right after a load
    a_no_pc_after_load: assert property (
        @(posedge clk) disable iff (!reset)
        ir_en |=> !pc_en
    );

endmodule

// File: hw/cr16_pkg.sv
// cr16 shared package with data widths, operation codes, flag positions and common types
package cr16_pkg;

    // data path widths
    localparam int WORD_W  = 16;
    localparam int IDX_W   = 4;
    localparam int OP_W    = 4;
    localparam int FLAGS_W = 5;

    localparam int NUM_REGS = 16; // general purpose register count

    typedef logic [WORD_W-1:0]  word_t;    // data word that also serves pc and instruction
    typedef logic [IDX_W-1:0]   reg_idx_t; // register index
    typedef logic [OP_W-1:0]    opcode_t;  // operation code
    typedef logic [FLAGS_W-1:0] flags_t;   // processor status flags

    // operation codes
    // register form takes these from bits 7:4, immediate form from bits 15:12
    localparam opcode_t OP_NOP  = 4'd0;
    localparam opcode_t OP_AND  = 4'd1;
    localparam opcode_t OP_OR   = 4'd2;
    localparam opcode_t OP_XOR  = 4'd3;
    localparam opcode_t OP_LSH  = 4'd4;
    localparam opcode_t OP_ADD  = 4'd5;
    localparam opcode_t OP_ADDU = 4'd6;
    localparam opcode_t OP_ADDC = 4'd7;
    localparam opcode_t OP_NOT  = 4'd8;
    localparam opcode_t OP_SUB  = 4'd9;
    localparam opcode_t OP_SUBC = 4'd10;
    localparam opcode_t OP_CMP  = 4'd11;
    localparam opcode_t OP_ASHU = 4'd12;
    localparam opcode_t OP_MOV  = 4'd13;
    // codes 14 and 15 are undefined and run as nop

    // flag bit positions inside flags_t
    localparam int FLAG_C = 0; // carry or borrow on subtract
    localparam int FLAG_L = 1; // unsigned lower
    localparam int FLAG_F = 2; // signed overflow
    localparam int FLAG_Z = 3; // equal
    localparam int FLAG_N = 4; // signed lower

    // immediate field
    localparam int IMM_W = 8;

endpackage

// File: hw/cr16_regfile.sv
// cr16 register file with sixteen words, two combinational reads and one write
`timescale 1ns/1ns
module cr16_regfile (
    input  logic            clk,
    input  logic            reset,
    cr16_ctrl_if.regs       ctrl,
    input  cr16_pkg::word_t wdata,     // alu result
    output cr16_pkg::word_t dest_data, // also operand a
    output cr16_pkg::word_t src_data
);
    import cr16_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0; // architectural state starts at zero
            end
        end else if (ctrl.reg_we) begin
            regs[ctrl.rdest] <= wdata;
        end
    end

    // reads are combinational, so execute sees settled operands
    assign dest_data = regs[ctrl.rdest];
    assign src_data  = regs[ctrl.rsrc];

    // a write is a single cycle pulse inside execute
    a_we_pulse: assert property (
        @(posedge clk) disable iff (!reset)
        ctrl.reg_we |-> ctrl.exec ##1 !ctrl.reg_we
    );

endmodule

// File: test/cr16_model.svh
// cr16 reference model giving the expected retire record of one instruction
`ifndef CR16_MODEL_SVH
`define CR16_MODEL_SVH

typedef struct packed {
    word_t       pc;
    logic        we;
    reg_idx_t    rdest;
    word_t       data;
    flags_t      flags_before; // shown during the retire
    flags_t      flags_after;  // shown one cycle later
    logic [31:0] cycle;        // monitor cycle of the retire
} retire_rec_t;

// a and b_reg are the mirrored registers named by bits 11:8 and 3:0
function automatic retire_rec_t predict_retire(input word_t ins, input word_t a,
                                               input word_t b_reg, input flags_t fl,
                                               input word_t pc);
    retire_rec_t r;
    opcode_t     op;
    word_t       b;
    logic        reg_form;
    int          ci;
    int          ua;
    int          ub;
    int          sa;
    int          sb;
    int          res;
    int          cnt;
    reg_form = (ins[15:12] == 4'h0);
    op       = reg_form ? ins[7:4] : ins[15:12];
    if (op == 4'd14 || op == 4'd15) begin
        op = OP_NOP; // undefined codes
    end
    // arithmetic and mov take a signed immediate, logic and shifts an unsigned one
    if (reg_form) begin
        b = b_reg;
    end else if ((op >= OP_ADD && op <= OP_ADDC) || (op >= OP_SUB && op <= OP_CMP)
                 || op == OP_MOV) begin
        b = {{8{ins[7]}}, ins[7:0]};
    end else begin
        b = {8'h00, ins[7:0]};
    end
    ci  = (op == OP_ADDC || op == OP_SUBC) ? int'(fl[FLAG_C]) : 0;
    ua  = a;
    ub  = b;
    sa  = $signed(a);
    sb  = $signed(b);
    cnt = b[4] ? int'(b[4:0]) - 32 : int'(b[4:0]); // five bit signed count
    r = '0;
    r.pc           = pc;
    r.rdest        = ins[11:8];
    r.we           = 1'b1;
    r.data         = a;
    r.flags_before = fl;
    r.flags_after  = fl;
    case (op)
        OP_ADD, OP_ADDU, OP_ADDC: begin
            res    = ua + ub + ci;
            r.data = res[15:0];
            if (op != OP_ADDU) begin
                r.flags_after[FLAG_C] = (res > 65535);
                res = sa + sb + ci;
                r.flags_after[FLAG_F] = (res > 32767) || (res < -32768);
            end
        end
        OP_SUB, OP_SUBC: begin
            res    = ua - ub - ci;
            r.data = res[15:0];
            r.flags_after[FLAG_C] = (res < 0); // borrow
            res = sa - sb - ci;
            r.flags_after[FLAG_F] = (res > 32767) || (res < -32768);
        end
        OP_CMP: begin
            r.we = 1'b0;
            r.flags_after[FLAG_Z] = (ua == ub);
            r.flags_after[FLAG_L] = (ua < ub);
            r.flags_after[FLAG_N] = (sa < sb);
        end
        OP_AND: r.data = a & b;
        OP_OR:  r.data = a | b;
        OP_XOR: r.data = a ^ b;
        OP_MOV: r.data = b;
        OP_NOT: r.data = ~b;
        OP_LSH, OP_ASHU: begin
            if (cnt >= 0) begin
                res = ua << cnt;
            end else if (op == OP_LSH) begin
                res = ua >> -cnt;  // zeros in from the top
            end else begin
                res = sa >>> -cnt; // sign copies in
            end
            r.data = res[15:0];
        end
        default: r.we = 1'b0; // nop leaves registers and flags untouched
    endcase
    return r;
endfunction

`endif

// File: test/cr16_tb.sv
// cr16 core testbench with LFSR stimulus, reference model, retire monitor and checks
`timescale 1ns/1ns
module cr16_tb;
    import cr16_pkg::*;
    `include "cr16_model.svh"

    logic     clk;
    logic     reset;
    logic     instr_valid;
    word_t    instr_data;
    logic     instr_ready;
    logic     retire_valid;
    word_t    retire_pc;
    logic     retire_we;
    reg_idx_t retire_rdest;
    word_t    retire_data;
    flags_t   flags;

    logic [31:0] lfsr = 32'hbcfb_67c7;
    word_t       mirror_regs [NUM_REGS];
    flags_t      mirror_flags;
    word_t       mirror_pc;
    retire_rec_t exp_q [$];       // accepted and not yet retired
    retire_rec_t head;
    flags_t      flags_due;       // checked one cycle after a retire
    logic        flags_pending = 1'b0;
    int unsigned cyc = 0;         // rising edges so far
    int          value_errs = 0;
    int          proto_errs = 0;
    int          timeouts = 0;
    logic        timed_out = 1'b0;

    // reset state, carry chain, immediates, cmp and nop, undefined codes, shifts
    word_t dir_prog [33] = '{
        16'h0253, 16'hD17F, 16'hD280, 16'hD3FF, 16'h0353, 16'h0471, 16'hD57F, 16'h4508,
        16'h25FF, 16'h5501, 16'h0691, 16'h07A0, 16'h2880, 16'h1881, 16'h38FF, 16'h890F,
        16'h6AFF, 16'hB17F, 16'h02B1, 16'h0000, 16'h01E2, 16'hF123, 16'hDA81, 16'h4A1C,
        16'hDB90, 16'hCB1E, 16'hDC03, 16'hCC04, 16'h4A10, 16'hDEFC, 16'hDDF0, 16'h0D4E,
        16'h0D3D
    };

    cr16_core dut0 (.*); // port names match one to one

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // fibonacci lfsr with taps 32 22 2 1 and one step per bit
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[14:0], fb};
        end
        return v;
    endfunction

    function automatic word_t random_instr();
        word_t w;
        w = rand_bits(16);
        if (rand_bits(1)) begin
            w[15:12] = 4'h0; // register form
        end
        return w;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            value_errs++;
            $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_rule(input logic ok, input string what);
        assert (ok) else begin
            proto_errs++;
            $display("ERROR %0t %s", $time, what);
        end
    endtask

    // predict on acceptance and advance the mirror
    task automatic accept_instr(input word_t ins);
        retire_rec_t r;
        r = predict_retire(ins, mirror_regs[ins[11:8]], mirror_regs[ins[3:0]],
                           mirror_flags, mirror_pc);
        r.cycle = cyc + 2; // accepting edge is cyc+1 and execute follows decode
        if (r.we) begin
            mirror_regs[r.rdest] = r.data;
        end
        mirror_flags = r.flags_after;
        mirror_pc    = mirror_pc + 1;
        exp_q.push_back(r);
    endtask

    // offer one instruction after a random gap and hold it until accepted
    task automatic send_instr(input word_t ins);
        int waited;
        if (timed_out) return;
        if (rand_bits(1)) begin
            repeat (rand_bits(2)) begin
                instr_valid = 1'b0;
                @(posedge clk);
                #5;
            end
        end
        instr_valid = 1'b1;
        instr_data  = ins;
        waited      = 0;
        @(negedge clk);
        while (!instr_ready && waited < 20) begin
            waited++;
            @(negedge clk);
        end
        @(posedge clk); // accepting edge
        #5;
        instr_valid = 1'b0;
        assert (waited < 20) else begin
            timeouts++;
            timed_out = 1'b1;
            $display("ERROR %0t timeout waiting for instr_ready", $time);
        end
    endtask

    // retire monitor on the falling edge
    always @(negedge clk) begin
        if (flags_pending) begin
            check_value("flags", flags_due, flags);
            flags_pending = 1'b0;
        end
        if (reset) begin
            if (exp_q.size() > 0) begin
                check_rule(!instr_ready, "instr_ready high with an instruction in flight");
            end
            if (retire_valid) begin
                if (exp_q.size() == 0) begin
                    check_rule(1'b0, "retire_valid high with no instruction in flight");
                end else begin
                    head = exp_q.pop_front();
                    check_rule(cyc == head.cycle, "retire not two cycles after acceptance");
                    check_value("retire_pc", head.pc, retire_pc);
                    check_value("retire_we", head.we, retire_we);
                    check_value("retire_rdest", head.rdest, retire_rdest);
                    if (head.we) begin
                        check_value("retire_data", head.data, retire_data);
                    end
                    check_value("flags", head.flags_before, flags); // older flags still
                    flags_due     = head.flags_after;
                    flags_pending = 1'b1;
                end
            end else if (exp_q.size() > 0 && cyc >= exp_q[0].cycle) begin
                check_rule(1'b0, "accepted instruction never retired");
                void'(exp_q.pop_front());
            end
            if (instr_valid && instr_ready) begin
                accept_instr(instr_data);
            end
        end
    end

    initial begin
        int waited;
        reset        = 1'b0;
        instr_valid  = 1'b0;
        instr_data   = '0;
        mirror_flags = '0;
        mirror_pc    = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            mirror_regs[i] = '0;
        end
        repeat (3) @(posedge clk);
        #5;
        reset = 1'b1;
        @(negedge clk);
        check_rule(instr_ready === 1'b1, "instr_ready not high after reset");
        check_rule(retire_valid === 1'b0, "retire_valid not low after reset");
        check_value("flags", '0, flags);
        @(posedge clk);
        #5;
        foreach (dir_prog[i]) begin
            send_instr(dir_prog[i]);
        end
        for (int n = 0; n < 200; n++) begin
            send_instr(random_instr());
        end
        waited = 0;
        // drain the retires and the last flag check
        while ((exp_q.size() > 0 || flags_pending) && waited < 20) begin
            waited++;
            @(negedge clk);
        end
        assert (exp_q.size() == 0) else begin
            timeouts++;
            $display("ERROR %0t timeout waiting for outstanding retires", $time);
        end
        $display("errors: %0d value, %0d protocol, %0d timeout", value_errs, proto_errs,
                 timeouts);
        if (value_errs + proto_errs + timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
